// File: src/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

////////////////////
// Data memory sizing

// Width of the processor byte address
// Low two bits pick the byte lane inside a word
`define MEM_ADDR_BITS 8

// Number of 32-bit words in the data RAM
// Follows from the byte address width
`define MEM_WORDS (1 << (`MEM_ADDR_BITS - 2))

// Word address width is MEM_ADDR_BITS - 2
// Used directly as `MEM_ADDR_BITS-3 in vector bounds

`endif

// File: src/mem_pkg.sv
package mem_pkg;

    ////////////////////
    // Memory operations

    // Load and store kinds from the processor side
    // Loads with a U suffix zero-extend
    typedef enum logic [2:0]
    {
        LB  = 3'd0,
        LBU = 3'd1,
        LH  = 3'd2,
        LHU = 3'd3,
        LW  = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    ////////////////////
    // Data word views

    // One 32-bit word seen two ways
    // Byte view for LB/LBU/SB and per-lane RAM writes
    // Halfword view for LH/LHU/SH
    // Lane 0 sits in bits 7:0, little-endian within the word
    typedef union packed
    {
        // Four byte lanes
        logic [3:0][7:0]  bytes;
        // Lower and upper halfword
        logic [1:0][15:0] halves;
    } mem_word_u;

    // Lane select bits map one to one onto bytes[]
    // sel[3] is the top byte

endpackage

// File: src/wb_if.sv
`timescale 1ns/1ns
`include "mem_macros.svh"

// Wishbone classic link between aligner and RAM
interface wb_if;

    ////////////////////
    // Master driven

    logic                      cyc;
    logic                      stb;
    logic                      we;
    // Byte lane enables
    logic [3:0]                sel;
    // Word address, not byte address
    logic [`MEM_ADDR_BITS-3:0] adr;
    logic [31:0]               dat_w;

    ////////////////////
    // Slave driven

    logic [31:0]               dat_r;
    // Single-cycle acknowledge
    logic                      ack;

    // Aligner side
    modport master (output cyc, stb, we, sel, adr, dat_w, input dat_r, ack);

    // RAM side
    modport slave (input cyc, stb, we, sel, adr, dat_w, output dat_r, ack);

endinterface

// File: src/lsu_align.sv
`timescale 1ns/1ns
`include "mem_macros.svh"

module lsu_align
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  mem_op_e                   op,
    input  logic [`MEM_ADDR_BITS-1:0] addr,
    input  logic [31:0]               wdata,
    output logic                      busy,
    output logic                      done,
    output logic                      err,
    output logic [31:0]               rdata,
    wb_if.master                      bus
);

    // FSM encoding
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_bus  = 2'd1;
    localparam logic [1:0] st_fin  = 2'd2;

    logic [1:0]                state;
    mem_op_e                   op_q;
    logic [`MEM_ADDR_BITS-1:0] addr_q;
    logic [31:0]               wdata_q;
    logic                      err_q;
    logic [31:0]               rdata_q;

    logic                      is_store;
    logic                      is_half;
    logic                      is_word;
    logic                      misaligned;
    logic                      bus_act;
    logic [3:0]                lane_sel;
    mem_word_u                 st_word;
    mem_word_u                 ld_word;
    logic [7:0]                ld_byte;
    logic [15:0]               ld_half;
    logic [31:0]               ld_value;

    ////////////////////
    // Op decode

    always_comb
    begin
        is_store   = (op_q == SB) || (op_q == SH) || (op_q == SW);
        is_half    = (op_q == LH) || (op_q == LHU) || (op_q == SH);
        is_word    = (op_q == LW) || (op_q == SW);
        // Halfword needs bit 0 clear, word needs both low bits clear
        misaligned = (is_half && addr_q[0]) || (is_word && (addr_q[1:0] != 2'b00));
    end

    // Byte enables from size and low address bits
    always_comb
    begin
        if (is_word)
            lane_sel = 4'b1111;
        else if (is_half)
            lane_sel = addr_q[1] ? 4'b1100 : 4'b0011;
        else
            lane_sel = 4'b0001 << addr_q[1:0];
    end

    ////////////////////
    // Store placement

    always_comb
    begin
        st_word = '0;
        case (op_q)
            SB:      st_word.bytes[addr_q[1:0]] = wdata_q[7:0];
            SH:      st_word.halves[addr_q[1]] = wdata_q[15:0];
            SW:      st_word.bytes = wdata_q;
            default: st_word = '0;
        endcase
    end

    ////////////////////
    // Load extraction

    assign ld_word = mem_word_u'(bus.dat_r);
    assign ld_byte = ld_word.bytes[addr_q[1:0]];
    assign ld_half = ld_word.halves[addr_q[1]];

    // Sign or zero extension per op
    always_comb
    begin
        case (op_q)
            LB:      ld_value = {{24{ld_byte[7]}}, ld_byte};
            LBU:     ld_value = {24'd0, ld_byte};
            LH:      ld_value = {{16{ld_half[15]}}, ld_half};
            LHU:     ld_value = {16'd0, ld_half};
            LW:      ld_value = bus.dat_r;
            // Stores report zero
            default: ld_value = '0;
        endcase
    end

    ////////////////////
    // Bus side

    // Misaligned requests spend their bus slot with cyc low
    assign bus_act   = (state == st_bus) && !misaligned;
    assign bus.cyc   = bus_act;
    assign bus.stb   = bus_act;
    assign bus.we    = is_store;
    assign bus.sel   = lane_sel;
    assign bus.adr   = addr_q[`MEM_ADDR_BITS-1:2];
    assign bus.dat_w = st_word;

    ////////////////////
    // Controller

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
            err_q <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    err_q <= 1'b0;
                    if (req)
                        state <= st_bus;
                end
                st_bus:
                begin
                    // Misaligned ends one cycle after acceptance
                    if (misaligned)
                    begin
                        state <= st_fin;
                        err_q <= 1'b1;
                    end
                    else if (bus.ack)
                        state <= st_fin;
                end
                default:
                begin
                    state <= st_idle;
                    err_q <= 1'b0;
                end
            endcase
        end
    end

    // Request and result registers
    always_ff @(posedge clk)
    begin
        if ((state == st_idle) && req)
        begin
            op_q    <= op;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == st_bus)
        begin
            if (misaligned)
                rdata_q <= '0;
            else if (bus.ack)
                rdata_q <= ld_value;
        end
    end

    assign busy  = (state != st_idle);
    assign done  = (state == st_fin);
    assign err   = err_q;
    assign rdata = rdata_q;

    // Open cycle held steady until the slave acks
    a_hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        (bus.stb && !bus.ack) |=> (bus.cyc && bus.stb
            && $stable({bus.we, bus.sel, bus.adr, bus.dat_w})))
        else $error("request dropped or changed before ack");

    // Cycle closes and completion follows right after ack
    a_done_after_ack: assert property (@(posedge clk) disable iff (rst)
        bus.ack |=> (done && !bus.stb))
        else $error("no done, or stb still high, after ack");

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ns
`include "mem_macros.svh"

module data_ram
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    wb_if.slave                       bus,
    input  logic [`MEM_ADDR_BITS-3:0] display_addr,
    output logic [31:0]               display_data
);

    // Word array
    mem_word_u                 mem [`MEM_WORDS];

    // Clearing sweep
    logic [`MEM_ADDR_BITS-3:0] clr_cnt;
    logic                      clr_active;

    // Bus response
    logic                      ack_q;
    logic [31:0]               dat_r_q;
    logic                      take;
    mem_word_u                 wr_word;

    ////////////////////
    // Request acceptance

    // New request seen, not yet acked, array ready
    assign take    = bus.cyc && bus.stb && !ack_q && !clr_active;
    assign wr_word = mem_word_u'(bus.dat_w);

    ////////////////////
    // Sweep and ack control

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            clr_cnt    <= '0;
            clr_active <= 1'b1;
            ack_q      <= 1'b0;
        end
        else
        begin
            // One word per cycle from address zero
            if (clr_active)
            begin
                clr_cnt <= clr_cnt + 1'b1;
                if (32'(clr_cnt) == `MEM_WORDS - 1)
                    clr_active <= 1'b0;
            end
            // Registered ack, drops the cycle after
            ack_q <= take;
        end
    end

    ////////////////////
    // Array access

    always_ff @(posedge clk)
    begin
        if (clr_active)
            mem[clr_cnt] <= '0;
        else if (take && bus.we)
        begin
            // Only enabled lanes change
            for (int i = 0; i < 4; i++)
            begin
                if (bus.sel[i])
                    mem[bus.adr].bytes[i] <= wr_word.bytes[i];
            end
        end

        // Full word back, the aligner picks the lane
        if (take)
            dat_r_q <= mem[bus.adr];

        // Display read
        // array counts as all zero while the sweep runs
        display_data <= clr_active ? 32'd0 : mem[display_addr];
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_r_q;

    // Ack stays inside the master's cycle
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        bus.ack |-> (bus.cyc && bus.stb))
        else $error("ack outside cyc/stb");

endmodule

// File: src/data_mem_top.sv
`timescale 1ns/1ns
`include "mem_macros.svh"

module data_mem_top
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    // Processor request
    input  logic                      req,
    input  mem_op_e                   op,
    input  logic [`MEM_ADDR_BITS-1:0] addr,
    input  logic [31:0]               wdata,
    // Processor response
    output logic                      busy,
    output logic                      done,
    output logic                      err,
    output logic [31:0]               rdata,
    // Display view, word addressed
    input  logic [`MEM_ADDR_BITS-3:0] display_addr,
    output logic [31:0]               display_data
);

    ////////////////////
    // Internal bus

    wb_if wb_bus ();

    // Load/store aligner as bus master
    lsu_align lsu_i
    (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .done  (done),
        .err   (err),
        .rdata (rdata),
        .bus   (wb_bus.master)
    );

    ////////////////////
    // Storage

    // Data RAM as bus slave
    data_ram ram_i
    (
        .clk          (clk),
        .rst          (rst),
        .bus          (wb_bus.slave),
        .display_addr (display_addr),
        .display_data (display_data)
    );

endmodule

// File: bench/mem_checker.sv
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_checker
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  mem_op_e                   op,
    input  logic [`MEM_ADDR_BITS-1:0] addr,
    input  logic [31:0]               wdata,
    input  logic                      busy,
    input  logic                      done,
    input  logic                      err,
    input  logic [31:0]               rdata,
    input  logic [`MEM_ADDR_BITS-3:0] display_addr,
    input  logic [31:0]               display_data,
    output int                        error_count,
    output int                        done_count
);

    // Shadow of the data RAM, word addressed
    logic [31:0]               shadow [`MEM_WORDS];

    // Request in flight
    logic                      pending;
    mem_op_e                   p_op;
    logic [`MEM_ADDR_BITS-1:0] p_addr;
    logic [31:0]               p_wdata;
    int                        p_cycle;

    // Edges since reset release
    int                        cycle;
    logic                      bus_done_seen;
    logic [`MEM_ADDR_BITS-3:0] disp_addr_q;

    ////////////////////
    // Reference model

    // Expected {err, rdata}
    // Stores report zero data
    function automatic logic [32:0] expected_result(input mem_op_e o,
        input logic [`MEM_ADDR_BITS-1:0] a, input logic [31:0] word);
        logic [31:0] lane;
        logic        bad;
        bad  = ((o == LH || o == LHU || o == SH) && a[0])
            || ((o == LW || o == SW) && (a[1:0] != 2'b00));
        // Addressed byte or halfword moved down to bit 0
        lane = word >> {a[1:0], 3'b000};
        if (bad)
            return {1'b1, 32'd0};
        case (o)
            LB:      return {1'b0, {24{lane[7]}}, lane[7:0]};
            LBU:     return {1'b0, 24'd0, lane[7:0]};
            LH:      return {1'b0, {16{lane[15]}}, lane[15:0]};
            LHU:     return {1'b0, 16'd0, lane[15:0]};
            LW:      return {1'b0, word};
            default: return 33'd0;
        endcase
    endfunction

    // Old word with the stored lanes replaced
    function automatic logic [31:0] merged_word(input mem_op_e o,
        input logic [`MEM_ADDR_BITS-1:0] a, input logic [31:0] old_word,
        input logic [31:0] data);
        logic [4:0]  shift;
        logic [31:0] mask;
        shift = {a[1:0], 3'b000};
        case (o)
            SB:      mask = 32'h0000_00ff << shift;
            SH:      mask = 32'h0000_ffff << shift;
            default: mask = 32'hffff_ffff;
        endcase
        return (old_word & ~mask) | ((data << shift) & mask);
    endfunction

    task automatic report_error(input string msg);
        error_count = error_count + 1;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    ////////////////////
    // Completion check

    task automatic check_done();
        logic [32:0]               expect_q;
        logic [`MEM_ADDR_BITS-3:0] w;
        done_count = done_count + 1;
        if (!pending)
            report_error("done with no request outstanding");
        else
        begin
            w        = p_addr[`MEM_ADDR_BITS-1:2];
            expect_q = expected_result(p_op, p_addr, shadow[w]);
            if ({err, rdata} !== expect_q)
                report_error($sformatf("%s at %h gave err %b rdata %h, expected err %b rdata %h",
                    p_op.name(), p_addr, err, rdata, expect_q[32], expect_q[31:0]));
            if (expect_q[32])
            begin
                // No bus cycle, done one cycle after acceptance
                if (cycle - p_cycle != 2)
                    report_error($sformatf("misaligned %s took %0d cycles",
                        p_op.name(), cycle - p_cycle));
            end
            else
            begin
                if (!bus_done_seen && cycle < `MEM_WORDS)
                    report_error("first bus access ended inside the clearing sweep");
                // Fixed latency once the sweep is over
                if (p_cycle >= `MEM_WORDS && cycle - p_cycle != 3)
                    report_error($sformatf("%s took %0d cycles", p_op.name(), cycle - p_cycle));
                bus_done_seen = 1'b1;
                if (p_op == SB || p_op == SH || p_op == SW)
                    shadow[w] = merged_word(p_op, p_addr, shadow[w], p_wdata);
            end
            pending = 1'b0;
        end
    endtask

    ////////////////////
    // Comparing process

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `MEM_WORDS; i++)
                shadow[i] = 32'd0;
            pending       = 1'b0;
            cycle         = 0;
            bus_done_seen = 1'b0;
            error_count   = 0;
            done_count    = 0;
            disp_addr_q   = '0;
        end
        else
        begin
            // Busy from acceptance through the done cycle
            if (busy !== pending)
                report_error($sformatf("busy is %b, expected %b", busy, pending));
            // Shadow updated first, display already shows the store
            if (done)
                check_done();
            if (req && !busy)
            begin
                if (pending)
                    report_error("second request accepted before done");
                pending = 1'b1;
                p_op    = op;
                p_addr  = addr;
                p_wdata = wdata;
                p_cycle = cycle;
            end
            // One edge of display latency
            if (cycle > 0 && display_data !== shadow[disp_addr_q])
                report_error($sformatf("display word %h is %h, expected %h",
                    disp_addr_q, display_data, shadow[disp_addr_q]));
            disp_addr_q = display_addr;
            cycle       = cycle + 1;
        end
    end

endmodule

// File: bench/tb_data_mem.sv
`timescale 1ns/1ns
`include "mem_macros.svh"

module tb_data_mem
    import mem_pkg::*;
();

    localparam int reset_cycles = 2;
    localparam int directed_ops = 98;
    localparam int random_ops   = 300;
    // Sweep plus 8 cycles per operation and a margin
    localparam int limit_cycles = reset_cycles + `MEM_WORDS
        + (directed_ops + random_ops) * 8 + 100;
    // Odd stride reaches every word
    localparam logic [`MEM_ADDR_BITS-3:0] disp_step = 7;

    logic                      clk          = 1'b0;
    logic                      rst          = 1'b1;
    logic                      req          = 1'b0;
    mem_op_e                   op           = LW;
    logic [`MEM_ADDR_BITS-1:0] addr         = '0;
    logic [31:0]               wdata        = '0;
    logic [`MEM_ADDR_BITS-3:0] display_addr = '0;
    logic                      busy;
    logic                      done;
    logic                      err;
    logic [31:0]               rdata;
    logic [31:0]               display_data;
    int                        error_count;
    int                        done_count;
    int                        ops_issued   = 0;
    integer                    seed         = 32'h5137_3940;

    always #2 clk = ~clk;

    // Port names match one to one
    data_mem_top dut_i (.*);
    mem_checker check_i (.*);

    // Display view scans while bus traffic runs
    always @(posedge clk)
        display_addr <= display_addr + disp_step;

    function automatic logic [`MEM_ADDR_BITS-1:0] to_addr(input int a);
        return a[`MEM_ADDR_BITS-1:0];
    endfunction

    // One request, then wait for done
    // req stays high while busy, the DUT must ignore it
    task automatic run_op(input mem_op_e o, input logic [`MEM_ADDR_BITS-1:0] a,
        input logic [31:0] d);
        req   <= 1'b1;
        op    <= o;
        addr  <= a;
        wdata <= d;
        // Acceptance edge
        @(posedge clk);
        do
            @(posedge clk);
        while (done !== 1'b1);
        req   <= 1'b0;
        // Idle edge before the next request
        @(posedge clk);
        ops_issued = ops_issued + 1;
    endtask

    initial
    begin
        logic [31:0]               r;
        logic [`MEM_ADDR_BITS-1:0] raddr;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // Every word reads zero after reset
        // First load waits out the sweep
        for (int w = 0; w < `MEM_WORDS; w++)
            run_op(LW, to_addr(4 * w), 32'd0);

        ////////////////////
        // Store merging
        run_op(SB, to_addr('h10), 32'h0000_0081);
        run_op(SB, to_addr('h11), 32'h0000_0002);
        run_op(SB, to_addr('h12), 32'h0000_00c3);
        run_op(SB, to_addr('h13), 32'h0000_0044);
        run_op(LW, to_addr('h10), 32'd0);
        run_op(SH, to_addr('h20), 32'hffff_8001);
        run_op(SH, to_addr('h22), 32'h0000_7ffe);
        run_op(LW, to_addr('h20), 32'd0);
        run_op(SW, to_addr('h30), 32'h1234_5678);
        run_op(SB, to_addr('h31), 32'h0000_00ab);
        run_op(SH, to_addr('h32), 32'h0000_f00d);
        run_op(LW, to_addr('h30), 32'd0);

        // Extension on lanes with top bit set and clear
        for (int i = 0; i < 4; i++)
        begin
            run_op(LB, to_addr('h10 + i), 32'd0);
            run_op(LBU, to_addr('h10 + i), 32'd0);
        end
        for (int i = 0; i < 2; i++)
        begin
            run_op(LH, to_addr('h20 + 2 * i), 32'd0);
            run_op(LHU, to_addr('h20 + 2 * i), 32'd0);
        end

        ////////////////////
        // Misaligned, then the same words again
        run_op(LH, to_addr('h21), 32'd0);
        run_op(LHU, to_addr('h23), 32'd0);
        run_op(LW, to_addr('h22), 32'd0);
        run_op(LW, to_addr('h11), 32'd0);
        run_op(SH, to_addr('h21), 32'hffff_ffff);
        run_op(SW, to_addr('h32), 32'hdead_beef);
        run_op(SW, to_addr('h13), 32'hdead_beef);
        run_op(LW, to_addr('h20), 32'd0);
        run_op(LW, to_addr('h30), 32'd0);
        run_op(LW, to_addr('h10), 32'd0);

        // Seeded mix over all ops and addresses
        for (int n = 0; n < random_ops; n++)
        begin
            r     = $random(seed);
            raddr = r[`MEM_ADDR_BITS+3:4];
            // Word-align about half so aligned word ops stay common
            if (r[3])
                raddr[1:0] = 2'b00;
            run_op(mem_op_e'(r[2:0]), raddr, $random(seed));
        end

        repeat (4) @(posedge clk);
        $display("errors %0d, operations %0d, completions %0d",
            error_count, ops_issued, done_count);
        if (error_count == 0 && done_count == ops_issued)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, run still going after %0d cycles, stopped", limit_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/mem_pkg.sv
src/wb_if.sv
src/lsu_align.sv
src/data_ram.sv
src/data_mem_top.sv
bench/mem_checker.sv
bench/tb_data_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_data_mem -f all.f \
    && ./obj_dir/Vtb_data_mem | tee /dev/stderr | grep -xF "all tests passed" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
